/* logic/legCore_settings.svh */
// widths, register file shape and opcode patterns for the LEGv8 core
// opcode patterns are 11 bits and use ? for don't-care bits, so match with casez or ==?
// unknown opcodes are not listed and execute as NOP
`ifndef LEG_CORE_SETTINGS_SVH
`define LEG_CORE_SETTINGS_SVH

// datapath and instruction widths
`define LEG_DATA_WIDTH 64
`define LEG_INSTR_WIDTH 32

// architectural registers, X31 is hardwired to zero
`define LEG_REG_COUNT 32
`define LEG_ZERO_REG 31

// byte step of the PC per fetched instruction
`define LEG_PC_STEP 4

// register ALU forms
`define LEG_OPC_ADD 11'b10001011000
`define LEG_OPC_SUB 11'b11001011000
`define LEG_OPC_AND 11'b10001010000
`define LEG_OPC_ORR 11'b10101010000
`define LEG_OPC_EOR 11'b11001010000
// immediate forms, low opcode bit is part of the immediate field
`define LEG_OPC_ADDI 11'b1001000100?
`define LEG_OPC_SUBI 11'b1101000100?
`define LEG_OPC_ANDI 11'b1001001000?
`define LEG_OPC_ORRI 11'b1011001000?
`define LEG_OPC_EORI 11'b1101001000?
// data transfer
`define LEG_OPC_LDUR 11'b11111000010
`define LEG_OPC_STUR 11'b11111000000
// all-zero instruction
`define LEG_OPC_NOP 11'b00000000000

`endif

/* logic/legCorePkg.sv */
// shared types of the LEGv8 core
// execCtrl_t and memCtrl_t hold the ID/EX and EX/MEM register contents

`include "legCore_settings.svh"

package legCorePkg;

  // data or address word
  typedef logic [`LEG_DATA_WIDTH-1:0] word_t;
  // raw instruction word
  typedef logic [`LEG_INSTR_WIDTH-1:0] instr_t;
  // register index, 5 bits for 32 registers
  typedef logic [$clog2(`LEG_REG_COUNT)-1:0] regIdx_t;

  // ALU function, no flag-setting variants
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluEor
  } aluOp_t;

  // data memory access of an instruction
  typedef enum logic [1:0] {
    memNone,
    memLoad,
    memStore
  } memOp_t;

  // decode to execute, ID/EX contents
  typedef struct packed {
    aluOp_t aluOp;
    // B from imm instead of register
    logic immSel;
    word_t opA;
    word_t opB;
    // zero-extended ALU imm or sign-extended offset
    word_t imm;
    regIdx_t destIdx;
    logic writeEnable;
    memOp_t memOp;
  } execCtrl_t;

  // execute to memory stage, EX/MEM contents
  typedef struct packed {
    word_t aluResult;
    word_t storeData;
    regIdx_t destIdx;
    logic writeEnable;
    memOp_t memOp;
  } memCtrl_t;

endpackage

/* logic/instrDecode.sv */
// PC, IF/ID register, decode and ID/EX register
// the PC steps every cycle, there are no branches and no stalls
// unknown opcodes decode as NOP with no register write and no memory access
`timescale 1ns/100ps

`include "legCore_settings.svh"

module instrDecode (
  input  logic                    clk,
  input  logic                    reset,
  input  legCorePkg::instr_t      instr,
  input  legCorePkg::word_t       readDataA,
  input  legCorePkg::word_t       readDataB,
  output legCorePkg::word_t       instrAddr,
  output legCorePkg::regIdx_t     readIdxA,
  output legCorePkg::regIdx_t     readIdxB,
  output legCorePkg::execCtrl_t   execCtrl
);

  legCorePkg::word_t pc;
  // IF/ID, resets to NOP
  legCorePkg::instr_t ifIdInstr;
  logic [10:0] opcode;
  legCorePkg::regIdx_t rn;
  legCorePkg::regIdx_t rm;
  legCorePkg::regIdx_t rd;
  legCorePkg::word_t aluImm;
  legCorePkg::word_t dtOffset;
  logic isStore;
  legCorePkg::execCtrl_t nextCtrl;

  // fetch address is the current PC
  assign instrAddr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      ifIdInstr <= '0;
    end else begin
      pc <= pc + `LEG_PC_STEP;
      ifIdInstr <= instr;
    end
  end

  // instruction fields
  assign opcode = ifIdInstr[31:21];
  assign rn = ifIdInstr[9:5];
  assign rm = ifIdInstr[20:16];
  assign rd = ifIdInstr[4:0];
  // 12-bit imm, zero-extended
  assign aluImm = legCorePkg::word_t'(ifIdInstr[21:10]);
  // 9-bit offset, sign-extended
  assign dtOffset = {{(`LEG_DATA_WIDTH-9){ifIdInstr[20]}}, ifIdInstr[20:12]};

  // stores read Rt through the B port
  assign isStore = (opcode ==? `LEG_OPC_STUR);
  assign readIdxA = rn;
  assign readIdxB = isStore ? rd : rm;

  always_comb begin
    // NOP unless matched below
    nextCtrl = '0;
    nextCtrl.aluOp = legCorePkg::aluAdd;
    nextCtrl.memOp = legCorePkg::memNone;
    nextCtrl.opA = readDataA;
    nextCtrl.opB = readDataB;
    nextCtrl.imm = aluImm;
    nextCtrl.destIdx = rd;
    casez (opcode)
      `LEG_OPC_ADD: nextCtrl.writeEnable = 1'b1;
      `LEG_OPC_SUB: begin
        nextCtrl.aluOp = legCorePkg::aluSub;
        nextCtrl.writeEnable = 1'b1;
      end
      `LEG_OPC_AND: begin
        nextCtrl.aluOp = legCorePkg::aluAnd;
        nextCtrl.writeEnable = 1'b1;
      end
      `LEG_OPC_ORR: begin
        nextCtrl.aluOp = legCorePkg::aluOrr;
        nextCtrl.writeEnable = 1'b1;
      end
      `LEG_OPC_EOR: begin
        nextCtrl.aluOp = legCorePkg::aluEor;
        nextCtrl.writeEnable = 1'b1;
      end
      // immediate forms share the register encodings of the ALU op
      `LEG_OPC_ADDI, `LEG_OPC_SUBI, `LEG_OPC_ANDI, `LEG_OPC_ORRI, `LEG_OPC_EORI: begin
        nextCtrl.immSel = 1'b1;
        nextCtrl.writeEnable = 1'b1;
        if (opcode ==? `LEG_OPC_SUBI) nextCtrl.aluOp = legCorePkg::aluSub;
        else if (opcode ==? `LEG_OPC_ANDI) nextCtrl.aluOp = legCorePkg::aluAnd;
        else if (opcode ==? `LEG_OPC_ORRI) nextCtrl.aluOp = legCorePkg::aluOrr;
        else if (opcode ==? `LEG_OPC_EORI) nextCtrl.aluOp = legCorePkg::aluEor;
      end
      // address is Rn plus offset, load writes Rt
      `LEG_OPC_LDUR: begin
        nextCtrl.immSel = 1'b1;
        nextCtrl.imm = dtOffset;
        nextCtrl.writeEnable = 1'b1;
        nextCtrl.memOp = legCorePkg::memLoad;
      end
      `LEG_OPC_STUR: begin
        nextCtrl.immSel = 1'b1;
        nextCtrl.imm = dtOffset;
        nextCtrl.memOp = legCorePkg::memStore;
      end
      // NOP and unknown opcodes
      default: nextCtrl.writeEnable = 1'b0;
    endcase
  end

  // ID/EX, control clears to NOP
  always_ff @(posedge clk) begin
    execCtrl.opA <= nextCtrl.opA;
    execCtrl.opB <= nextCtrl.opB;
    execCtrl.imm <= nextCtrl.imm;
    execCtrl.destIdx <= nextCtrl.destIdx;
    if (reset) begin
      execCtrl.aluOp <= legCorePkg::aluAdd;
      execCtrl.immSel <= 1'b0;
      execCtrl.writeEnable <= 1'b0;
      execCtrl.memOp <= legCorePkg::memNone;
    end else begin
      execCtrl.aluOp <= nextCtrl.aluOp;
      execCtrl.immSel <= nextCtrl.immSel;
      execCtrl.writeEnable <= nextCtrl.writeEnable;
      execCtrl.memOp <= nextCtrl.memOp;
    end
  end

endmodule

/* logic/regFile.sv */
// 31 writable 64-bit registers plus X31, which reads zero
// two combinational read ports, one write port on the rising edge
// a read of the register being written returns the new data
`timescale 1ns/100ps

`include "legCore_settings.svh"

module regFile (
  input  logic                 clk,
  input  logic                 reset,
  input  legCorePkg::regIdx_t  readIdxA,
  input  legCorePkg::regIdx_t  readIdxB,
  input  legCorePkg::regIdx_t  writeIdx,
  input  legCorePkg::word_t    writeData,
  input  logic                 writeEnable,
  output legCorePkg::word_t    readDataA,
  output legCorePkg::word_t    readDataB
);

  // X0..X30 only, no storage for the zero register
  legCorePkg::word_t regs [`LEG_REG_COUNT-1];
  logic doWrite;

  // writes to X31 are dropped
  assign doWrite = writeEnable && (writeIdx != legCorePkg::regIdx_t'(`LEG_ZERO_REG));

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `LEG_REG_COUNT - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (doWrite) begin
      regs[writeIdx] <= writeData;
    end
  end

  // zero reg first, then write-through, then storage
  always_comb begin
    if (readIdxA == legCorePkg::regIdx_t'(`LEG_ZERO_REG)) readDataA = '0;
    else if (doWrite && (writeIdx == readIdxA)) readDataA = writeData;
    else readDataA = regs[readIdxA];
  end

  always_comb begin
    if (readIdxB == legCorePkg::regIdx_t'(`LEG_ZERO_REG)) readDataB = '0;
    else if (doWrite && (writeIdx == readIdxB)) readDataB = writeData;
    else readDataB = regs[readIdxB];
  end

endmodule

/* logic/aluExecute.sv */
// execute stage, operand select, 64-bit ALU and EX/MEM register
// add and subtract wrap around, no flags and no carry out
// loads and stores arrive from decode with immSel set and an add op
`timescale 1ns/100ps

module aluExecute (
  input  logic                   clk,
  input  logic                   reset,
  input  legCorePkg::execCtrl_t  execCtrl,
  output legCorePkg::memCtrl_t   memCtrl
);

  legCorePkg::word_t operandA;
  legCorePkg::word_t operandB;
  legCorePkg::word_t result;

  assign operandA = execCtrl.opA;
  // imm forms and address offsets take B from the imm field
  assign operandB = execCtrl.immSel ? execCtrl.imm : execCtrl.opB;

  always_comb begin
    case (execCtrl.aluOp)
      legCorePkg::aluAdd: result = operandA + operandB;
      legCorePkg::aluSub: result = operandA - operandB;
      legCorePkg::aluAnd: result = operandA & operandB;
      legCorePkg::aluOrr: result = operandA | operandB;
      legCorePkg::aluEor: result = operandA ^ operandB;
      default: result = operandA + operandB;
    endcase
  end

  // EX/MEM
  // store data is the register B value, not the selected operand
  always_ff @(posedge clk) begin
    memCtrl.aluResult <= result;
    memCtrl.storeData <= execCtrl.opB;
    memCtrl.destIdx <= execCtrl.destIdx;
    if (reset) begin
      memCtrl.writeEnable <= 1'b0;
      memCtrl.memOp <= legCorePkg::memNone;
    end else begin
      memCtrl.writeEnable <= execCtrl.writeEnable;
      memCtrl.memOp <= execCtrl.memOp;
    end
  end

endmodule

/* logic/memWriteback.sv */
// memory stage and writeback
// drives the single-cycle data port from EX/MEM, load data must be valid
// in the same cycle; MEM/WB feeds the register file write port
`timescale 1ns/100ps

module memWriteback (
  input  logic                  clk,
  input  logic                  reset,
  input  legCorePkg::memCtrl_t  memCtrl,
  input  legCorePkg::word_t     dataRead,
  output legCorePkg::word_t     dataAddr,
  output legCorePkg::word_t     dataWrite,
  output logic                  storeEnable,
  output logic                  loadEnable,
  output legCorePkg::regIdx_t   writeIdx,
  output legCorePkg::word_t     writeData,
  output logic                  writeEnable
);

  // ALU result is the effective address for loads and stores
  assign dataAddr = memCtrl.aluResult;
  assign dataWrite = memCtrl.storeData;
  assign storeEnable = (memCtrl.memOp == legCorePkg::memStore);
  assign loadEnable = (memCtrl.memOp == legCorePkg::memLoad);

  // MEM/WB
  always_ff @(posedge clk) begin
    writeData <= loadEnable ? dataRead : memCtrl.aluResult;
    writeIdx <= memCtrl.destIdx;
    if (reset) begin
      writeEnable <= 1'b0;
    end else begin
      writeEnable <= memCtrl.writeEnable;
    end
  end

endmodule

/* logic/legCore.sv */
// five-stage LEGv8 integer core, top level
// no hazard detection and no forwarding, keep two instructions between
// a register write and its next read
// instruction and data memories answer combinationally in the same cycle
`timescale 1ns/100ps

module legCore (
  input  logic                 clk,
  input  logic                 reset,
  // fetch port
  output legCorePkg::word_t    instrAddr,
  input  legCorePkg::instr_t   instr,
  // data port, valid in the memory stage
  output legCorePkg::word_t    dataAddr,
  output legCorePkg::word_t    dataWrite,
  output logic                 storeEnable,
  output logic                 loadEnable,
  input  legCorePkg::word_t    dataRead
);

  // register file read side
  legCorePkg::regIdx_t readIdxA;
  legCorePkg::regIdx_t readIdxB;
  legCorePkg::word_t readDataA;
  legCorePkg::word_t readDataB;

  // register file write side from writeback
  legCorePkg::regIdx_t writeIdx;
  legCorePkg::word_t writeData;
  logic writeEnable;

  // stage boundaries
  legCorePkg::execCtrl_t execCtrl;
  legCorePkg::memCtrl_t memCtrl;

  // fetch and decode, PC lives here
  instrDecode i_instrDecode (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .readDataA (readDataA),
    .readDataB (readDataB),
    .instrAddr (instrAddr),
    .readIdxA  (readIdxA),
    .readIdxB  (readIdxB),
    .execCtrl  (execCtrl)
  );

  regFile i_regFile (
    .clk         (clk),
    .reset       (reset),
    .readIdxA    (readIdxA),
    .readIdxB    (readIdxB),
    .writeIdx    (writeIdx),
    .writeData   (writeData),
    .writeEnable (writeEnable),
    .readDataA   (readDataA),
    .readDataB   (readDataB)
  );

  aluExecute i_aluExecute (
    .clk      (clk),
    .reset    (reset),
    .execCtrl (execCtrl),
    .memCtrl  (memCtrl)
  );

  // memory access and writeback
  memWriteback i_memWriteback (
    .clk         (clk),
    .reset       (reset),
    .memCtrl     (memCtrl),
    .dataRead    (dataRead),
    .dataAddr    (dataAddr),
    .dataWrite   (dataWrite),
    .storeEnable (storeEnable),
    .loadEnable  (loadEnable),
    .writeIdx    (writeIdx),
    .writeData   (writeData),
    .writeEnable (writeEnable)
  );

endmodule

/* tb/legCore_props.sv */
// concurrent checks on the fetch PC and the data port controls
// bound into every legCore instance, failures also bump propFails
// test programs only use 8-byte aligned data addresses
`timescale 1ns/100ps

`include "legCore_settings.svh"

module legCoreProps (
  input logic               clk,
  input logic               reset,
  input legCorePkg::word_t  instrAddr,
  input legCorePkg::word_t  dataAddr,
  input logic               storeEnable,
  input logic               loadEnable
);

  // failure count, watched by the testbench
  int propFails = 0;

  // first cycle out of reset, PC at zero and no memory access
  resetState: assert property (@(posedge clk)
      $fell(reset) |-> (instrAddr == '0) && !storeEnable && !loadEnable)
    else begin
      $error("PC or memory controls wrong in first cycle after reset");
      propFails++;
    end

  // PC steps every cycle, no branches
  pcStep: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> instrAddr == $past(instrAddr) + `LEG_PC_STEP)
    else begin
      $error("PC did not advance by one instruction");
      propFails++;
    end

  memCtrlKnown: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({storeEnable, loadEnable}))
    else begin
      $error("storeEnable or loadEnable unknown");
      propFails++;
    end

  // one memory op per cycle
  memExclusive: assert property (@(posedge clk) disable iff (reset)
      !(storeEnable && loadEnable))
    else begin
      $error("storeEnable and loadEnable high together");
      propFails++;
    end

  loadAligned: assert property (@(posedge clk) disable iff (reset)
      loadEnable |-> dataAddr[2:0] == 3'b000)
    else begin
      $error("load address not word aligned");
      propFails++;
    end

  storeAligned: assert property (@(posedge clk) disable iff (reset)
      storeEnable |-> dataAddr[2:0] == 3'b000)
    else begin
      $error("store address not word aligned");
      propFails++;
    end

endmodule

bind legCore legCoreProps i_props (
  .clk         (clk),
  .reset       (reset),
  .instrAddr   (instrAddr),
  .dataAddr    (dataAddr),
  .storeEnable (storeEnable),
  .loadEnable  (loadEnable)
);

/* tb/legCoreTb.sv */
// testbench for the LEGv8 core
// programs are assembled up front and stepped through a reference model,
// which queues the expected store and load traffic in program order
// data memory is 64 words, byte addresses 0..511, upper address bits ignored
`timescale 1ns/100ps

`include "legCore_settings.svh"

module legCoreTb;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 3;
  localparam int ImemDepth = 2048;

  logic clk;
  logic reset;
  legCorePkg::word_t instrAddr;
  legCorePkg::instr_t instr;
  legCorePkg::word_t dataAddr;
  legCorePkg::word_t dataWrite;
  logic storeEnable;
  logic loadEnable;
  legCorePkg::word_t dataRead;

  // DUT side memories
  legCorePkg::instr_t imem [ImemDepth];
  legCorePkg::word_t dmem [64];
  // architectural reference state
  legCorePkg::word_t modelRegs [32];
  legCorePkg::word_t modelMem [64];
  // program slot of the last writer of each register
  int lastWrite [32];
  int progLen;
  legCorePkg::word_t storeAddrQ [$];
  legCorePkg::word_t storeDataQ [$];
  legCorePkg::word_t loadAddrQ [$];

  legCore i_dut (
    .clk         (clk),
    .reset       (reset),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .dataAddr    (dataAddr),
    .dataWrite   (dataWrite),
    .storeEnable (storeEnable),
    .loadEnable  (loadEnable),
    .dataRead    (dataRead)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  task automatic failRun(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input legCorePkg::word_t got,
                                input legCorePkg::word_t exp);
    $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    failRun("data port value differs from the reference model");
  endtask

  // ALU ops indexed 0..4 as add, sub, and, orr, eor
  function automatic logic [10:0] regOpcode(input int op);
    case (op)
      0: return `LEG_OPC_ADD;
      1: return `LEG_OPC_SUB;
      2: return `LEG_OPC_AND;
      3: return `LEG_OPC_ORR;
      default: return `LEG_OPC_EOR;
    endcase
  endfunction

  // imm forms, low pattern bit belongs to the imm field
  function automatic logic [9:0] immOpcode(input int op);
    logic [10:0] full;
    case (op)
      0: full = `LEG_OPC_ADDI;
      1: full = `LEG_OPC_SUBI;
      2: full = `LEG_OPC_ANDI;
      3: full = `LEG_OPC_ORRI;
      default: full = `LEG_OPC_EORI;
    endcase
    return full[10:1];
  endfunction

  function automatic legCorePkg::word_t aluRef(input int op, input legCorePkg::word_t a,
                                               input legCorePkg::word_t b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      default: return a ^ b;
    endcase
  endfunction

  // X31 reads zero, writes to it vanish
  function automatic legCorePkg::word_t readModel(input int r);
    return (r == `LEG_ZERO_REG) ? '0 : modelRegs[r];
  endfunction

  function automatic void writeModel(input int r, input legCorePkg::word_t v);
    if (r != `LEG_ZERO_REG) modelRegs[r] = v;
  endfunction

  // no forwarding in the core, so pad with NOPs until 2 slots separate writer and reader
  task automatic emit(input legCorePkg::instr_t word, input int srcA, input int srcB,
                      input int dest);
    while (progLen - lastWrite[srcA] < 3 || progLen - lastWrite[srcB] < 3) begin
      imem[progLen] = '0;
      progLen++;
    end
    imem[progLen] = word;
    if (dest >= 0 && dest != `LEG_ZERO_REG) lastWrite[dest] = progLen;
    progLen++;
  endtask

  task automatic opReg(input int op, input int rd, input int rn, input int rm);
    writeModel(rd, aluRef(op, readModel(rn), readModel(rm)));
    emit({regOpcode(op), 5'(rm), 6'd0, 5'(rn), 5'(rd)}, rn, rm, rd);
  endtask

  // imm is zero-extended
  task automatic opImm(input int op, input int rd, input int rn, input logic [11:0] imm);
    writeModel(rd, aluRef(op, readModel(rn), legCorePkg::word_t'(imm)));
    emit({immOpcode(op), imm, 5'(rn), 5'(rd)}, rn, `LEG_ZERO_REG, rd);
  endtask

  // offset is sign-extended from 9 bits
  task automatic load(input int rt, input int rn, input logic [8:0] off);
    legCorePkg::word_t addr;
    addr = readModel(rn) + {{(`LEG_DATA_WIDTH - 9){off[8]}}, off};
    loadAddrQ.push_back(addr);
    writeModel(rt, modelMem[addr[8:3]]);
    emit({`LEG_OPC_LDUR, off, 2'b00, 5'(rn), 5'(rt)}, rn, `LEG_ZERO_REG, rt);
  endtask

  task automatic store(input int rt, input int rn, input logic [8:0] off);
    legCorePkg::word_t addr;
    addr = readModel(rn) + {{(`LEG_DATA_WIDTH - 9){off[8]}}, off};
    storeAddrQ.push_back(addr);
    storeDataQ.push_back(readModel(rt));
    modelMem[addr[8:3]] = readModel(rt);
    emit({`LEG_OPC_STUR, off, 2'b00, 5'(rn), 5'(rt)}, rn, rt, -1);
  endtask

  task automatic buildProgram();
    int op;
    int rd;
    // register ALU ops on ADDI-loaded operands, 0 - 1 gives all ones
    opImm(0, 1, 31, 12'h7ff);
    opImm(0, 2, 31, 12'h0a5);
    opImm(1, 3, 31, 12'h001);
    opReg(0, 4, 1, 2);
    opReg(1, 5, 2, 1);
    opReg(2, 6, 3, 1);
    opReg(3, 7, 1, 2);
    opReg(4, 8, 3, 2);
    for (int r = 4; r <= 8; r++) store(r, 31, 9'(8 * r));
    // imm forms, then negative offsets from base 256
    opImm(2, 9, 3, 12'hf0f);
    opImm(3, 10, 2, 12'hf00);
    opImm(4, 11, 3, 12'h0ff);
    opImm(1, 12, 1, 12'hfff);
    opImm(0, 13, 31, 12'h100);
    store(9, 13, 9'h1f8);
    store(10, 13, 9'h1f0);
    store(11, 13, 9'h100);
    store(12, 13, 9'h180);
    // preloaded words and one stored above, copied back out
    load(14, 13, 9'd144);
    load(15, 13, 9'd248);
    load(18, 31, 9'd32);
    opReg(0, 16, 14, 15);
    store(14, 31, 9'd120);
    store(15, 31, 9'd112);
    store(16, 31, 9'd104);
    store(18, 31, 9'd96);
    // X31 drops writes, NOP and unknown opcode change nothing
    opImm(0, 31, 1, 12'h123);
    store(31, 31, 9'd88);
    opReg(0, 17, 31, 1);
    // X0 nonzero so a NOP writing its Rd field would show
    opImm(0, 0, 31, 12'h456);
    emit('0, 31, 31, -1);
    emit({11'h7ff, 21'h000001}, 31, 31, -1);
    store(17, 31, 9'd80);
    store(1, 31, 9'd72);
    store(0, 31, 9'd184);
    // random ALU and imm ops, destination stored every fourth
    for (int i = 0; i < 200; i++) begin
      op = $urandom_range(4);
      rd = $urandom_range(31);
      if ($urandom_range(1) == 1) opReg(op, rd, $urandom_range(31), $urandom_range(31));
      else opImm(op, rd, $urandom_range(31), 12'($urandom));
      if (i % 4 == 3) store(rd, 31, 9'(8 * $urandom_range(31)));
    end
    for (int r = 0; r < 31; r++) store(r, 31, 9'(8 * r));
  endtask

  // inputs change on the falling edge, data port checked there too
  always @(negedge clk) begin
    if (i_dut.i_props.propFails != 0) failRun("a bound property of the core failed");
    if (storeEnable) begin
      assert (storeAddrQ.size() > 0) else failRun("store seen after the last program store");
      assert (dataAddr == storeAddrQ[0]) else reportMismatch("dataAddr", dataAddr, storeAddrQ[0]);
      assert (dataWrite == storeDataQ[0]) else reportMismatch("dataWrite", dataWrite, storeDataQ[0]);
      void'(storeAddrQ.pop_front());
      void'(storeDataQ.pop_front());
      dmem[dataAddr[8:3]] = dataWrite;
    end
    if (loadEnable) begin
      assert (loadAddrQ.size() > 0) else failRun("load seen after the last program load");
      assert (dataAddr == loadAddrQ[0]) else reportMismatch("dataAddr", dataAddr, loadAddrQ[0]);
      void'(loadAddrQ.pop_front());
    end
    dataRead = dmem[dataAddr[8:3]];
    // past the program end fetch returns NOP
    if (instrAddr < legCorePkg::word_t'(progLen * 4)) instr = imem[instrAddr[12:2]];
    else instr = '0;
  end

  initial begin
    int timeoutNs;
    reset = 1'b1;
    instr = '0;
    dataRead = '0;
    progLen = 0;
    void'($urandom(13));
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = '0;
      lastWrite[r] = -10;
    end
    // fill pattern covers every index bit
    for (int i = 0; i < 64; i++) begin
      dmem[i] = {32'hfeed0000 + 32'(i), 32'h13579bdf ^ (32'(i) * 32'h01010101)};
      modelMem[i] = dmem[i];
    end
    buildProgram();
    timeoutNs = (ResetCycles + progLen + 20) * ClkPeriod;
    fork
      begin
        #(timeoutNs);
        failRun("run timed out before the program drained");
      end
    join_none
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    // last instruction leaves writeback four cycles after its fetch
    while (instrAddr < legCorePkg::word_t'((progLen + 5) * 4)) @(negedge clk);
    if (storeAddrQ.size() != 0 || loadAddrQ.size() != 0) begin
      failRun("program ended with expected stores or loads missing");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+logic
logic/legCorePkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/memWriteback.sv
logic/legCore.sv
tb/legCore_props.sv
tb/legCoreTb.sv
